// ==== hdl/vdp_pkg.sv ====
`default_nettype none

package vdp_pkg;

  // --------------------
  // Memory word and address types
  typedef logic [13:0] vram_addr_t;  // 16 KB VRAM
  typedef logic [7:0]  vram_byte_t;
  typedef logic [4:0]  cram_addr_t;  // 32 palette entries
  typedef logic [5:0]  color_t;      // {b, g, r}, 2 bits each

  // Raster position, rows run past 511 so both need 10 bits
  typedef logic [9:0] col_t;
  typedef logic [9:0] row_t;

  // Opcode in bits 7:6 of the second control byte
  typedef enum logic [1:0] {
    op_vram_read  = 2'd0,
    op_vram_write = 2'd1,
    op_reg_write  = 2'd2,
    op_cram_write = 2'd3
  } cmd_op_t;

  // --------------------
  // 640x480 raster, 25 MHz style timing
  localparam col_t h_total      = 10'd800;
  localparam col_t h_active     = 10'd640;
  localparam col_t h_sync_start = 10'd656;
  localparam col_t h_sync_end   = 10'd752;
  localparam row_t v_total      = 10'd525;
  localparam row_t v_active     = 10'd480;
  localparam row_t v_sync_start = 10'd490;
  localparam row_t v_sync_end   = 10'd492;

  // 256x192 picture doubled, centered in the raster
  localparam col_t act_col_start = 10'd64;
  localparam col_t act_cols      = 10'd512;
  localparam row_t act_row_start = 10'd48;
  localparam row_t act_rows      = 10'd384;

  localparam vram_addr_t name_table_base = 14'h3800;
  localparam cram_addr_t backdrop_base   = 5'd16;   // Sprite half of CRAM

  localparam int pipe_depth = 3;  // Raster position to pixel out
  localparam logic [7:0] default_ctrl_port = 8'hBF;

endpackage : vdp_pkg

`default_nettype wire

// ==== hdl/vdp_dp_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module vdp_dp_ram #(
  parameter type word_t = logic [7:0],
  parameter int depth = 256,
  localparam int aw = $clog2(depth)
) (
  input  logic          clk,
  input  logic [aw-1:0] a_addr,   // CPU side, read/write
  input  logic          a_we,
  input  word_t         a_wdata,
  output word_t         a_rdata,
  input  logic [aw-1:0] b_addr,   // Display side, read only
  output word_t         b_rdata
);

  word_t mem [depth];

  // Port A, read returns old contents on a write
  always_ff @(posedge clk) begin
    if (a_we) mem[a_addr] <= a_wdata;
    a_rdata <= mem[a_addr];
  end

  // Port B
  always_ff @(posedge clk) begin
    b_rdata <= mem[b_addr];
  end

endmodule : vdp_dp_ram

`default_nettype wire

// ==== hdl/vdp_raster.sv ====
`timescale 1ns/1ps
`default_nettype none

module vdp_raster (
  input  logic          clk,
  input  logic          rst_L,
  output vdp_pkg::col_t col,
  output vdp_pkg::row_t row,
  output logic          h_sync,   // Active low
  output logic          v_sync    // Active low
);

  import vdp_pkg::*;

  // --------------------
  // Column and row counters
  always_ff @(posedge clk, negedge rst_L) begin
    if (!rst_L) begin
      col <= '0;
      row <= '0;
    end else if (col == col_t'(h_total - 1)) begin
      col <= '0;
      if (row == row_t'(v_total - 1)) row <= '0;  // End of frame
      else                           row <= row + 1'b1;
    end else begin
      col <= col + 1'b1;
    end
  end

  // Sync pulses straight off the counters
  assign h_sync = !((col >= h_sync_start) && (col < h_sync_end));
  assign v_sync = !((row >= v_sync_start) && (row < v_sync_end));

endmodule : vdp_raster

`default_nettype wire

// ==== hdl/vdp_pixel_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

module vdp_pixel_pipe (
  input  logic                clk,
  input  logic                rst_L,
  input  vdp_pkg::col_t       col,
  input  vdp_pkg::row_t       row,
  input  logic                h_sync,
  input  logic                v_sync,
  input  logic                disp_en,
  input  logic [3:0]          backdrop,
  output vdp_pkg::vram_addr_t vram_addr,
  input  vdp_pkg::vram_byte_t vram_rdata,
  output vdp_pkg::cram_addr_t cram_addr,
  input  vdp_pkg::color_t     cram_rdata,
  output logic                vga_hs,
  output logic                vga_vs,
  output logic [3:0]          vga_r,
  output logic [3:0]          vga_g,
  output logic [3:0]          vga_b
);

  import vdp_pkg::*;

  col_t act_c;                        // Column inside the picture
  row_t act_r;
  logic active0, vis0;
  logic act1, vis1, act2, vis2, vis3; // Flags per stage
  logic show;
  logic [pipe_depth-1:0] hs_dly, vs_dly;

  // 2 bits to 4 by replication, 0/5/10/15
  function automatic logic [3:0] expand(input logic [1:0] c);
    return {c, c};
  endfunction

  // --------------------
  // Stage 1, name table address
  assign act_c   = col - act_col_start;
  assign act_r   = row - act_row_start;
  assign active0 = (col >= act_col_start) && (col < act_col_start + act_cols) &&
                   (row >= act_row_start) && (row < act_row_start + act_rows);
  assign vis0    = (col < h_active) && (row < v_active);

  always_ff @(posedge clk) begin
    // 16x16 screen pixels per cell, 32 cells per row
    vram_addr <= name_table_base + vram_addr_t'({act_r[8:4], act_c[8:4]});
  end

  always_ff @(posedge clk, negedge rst_L) begin
    if (!rst_L) begin
      act1   <= 1'b0;
      vis1   <= 1'b0;
      act2   <= 1'b0;
      vis2   <= 1'b0;
      vis3   <= 1'b0;
      hs_dly <= '1;   // Syncs idle high
      vs_dly <= '1;
    end else begin
      act1   <= active0;
      vis1   <= vis0;
      act2   <= act1;   // Name byte arrives with stage 2
      vis2   <= vis1;
      vis3   <= vis2;
      hs_dly <= {hs_dly[pipe_depth-2:0], h_sync};
      vs_dly <= {vs_dly[pipe_depth-2:0], v_sync};
    end
  end

  // --------------------
  // Stage 2, palette index, border falls back to the backdrop
  assign cram_addr = act2 ? {1'b0, vram_rdata[3:0]}
                          : backdrop_base + {1'b0, backdrop};

  // Stage 3, color out, blanked outside 640x480
  assign show  = disp_en && vis3;
  assign vga_r = show ? expand(cram_rdata[1:0]) : 4'd0;
  assign vga_g = show ? expand(cram_rdata[3:2]) : 4'd0;
  assign vga_b = show ? expand(cram_rdata[5:4]) : 4'd0;

  assign vga_hs = hs_dly[pipe_depth-1];
  assign vga_vs = vs_dly[pipe_depth-1];

endmodule : vdp_pixel_pipe

`default_nettype wire

// ==== hdl/vdp_cpu_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module vdp_cpu_port #(
  parameter logic [7:0] ctrl_port = vdp_pkg::default_ctrl_port
) (
  input  logic                clk,
  input  logic                rst_L,
  input  logic                iorq_l,
  input  logic                rd_l,
  input  logic                wr_l,
  input  logic [7:0]          bus_addr,
  input  logic [7:0]          bus_din,
  output logic [7:0]          bus_dout,
  output logic                bus_oe,
  output vdp_pkg::vram_addr_t vram_addr,
  output logic                vram_we,
  output vdp_pkg::vram_byte_t vram_wdata,
  input  vdp_pkg::vram_byte_t vram_rdata,
  output vdp_pkg::cram_addr_t cram_addr,
  output logic                cram_we,
  output vdp_pkg::color_t     cram_wdata,
  output logic                disp_en,    // Reg 1 bit 6
  output logic [3:0]          backdrop    // Reg 7 low nibble
);

  import vdp_pkg::*;

  typedef enum logic {
    seq_low,   // Waiting for first control byte
    seq_high   // Waiting for opcode byte
  } seq_t;

  seq_t       seq;
  cmd_op_t    op, new_op;
  vram_addr_t addr;         // Shared VRAM/CRAM address counter
  vram_byte_t low_byte;
  vram_byte_t rd_buf;       // Read-ahead buffer
  logic       idle;         // Strobe decoder ready
  logic       rd_active;    // Data read in progress
  logic       strobe, acc, is_ctrl, is_wr;
  logic       acc_ctrl_wr, acc_data_wr, acc_data_rd;
  logic       fetch_pend, fetch_go, fetch_dly;

  // --------------------
  // Strobe decoder
  assign strobe  = !iorq_l && (!rd_l || !wr_l);
  assign acc     = strobe && idle && !fetch_pend;  // One access per strobe
  assign is_ctrl = (bus_addr == ctrl_port);        // Any other port is data
  assign is_wr   = !wr_l;

  assign acc_ctrl_wr = acc && is_ctrl && is_wr;
  assign acc_data_wr = acc && !is_ctrl && is_wr;
  assign acc_data_rd = acc && !is_ctrl && !is_wr;  // Control reads do nothing

  always_ff @(posedge clk, negedge rst_L) begin
    if (!rst_L) begin
      idle      <= 1'b1;
      rd_active <= 1'b0;
    end else if (acc) begin
      idle      <= 1'b0;
      rd_active <= !is_ctrl && !is_wr;
    end else if (iorq_l) begin   // Strobe gone, rearm
      idle      <= 1'b1;
      rd_active <= 1'b0;
    end
  end

  assign bus_oe   = rd_active && !iorq_l;
  assign bus_dout = rd_buf;

  // --------------------
  // Command FSM and address counter
  assign new_op   = cmd_op_t'(bus_din[7:6]);
  assign fetch_go = idle && fetch_pend;   // Prefetch waits for the bus to go quiet

  always_ff @(posedge clk, negedge rst_L) begin
    if (!rst_L) begin
      seq        <= seq_low;
      op         <= op_vram_read;
      addr       <= '0;
      fetch_pend <= 1'b0;
      fetch_dly  <= 1'b0;
      disp_en    <= 1'b0;
      backdrop   <= 4'd0;
    end else begin
      fetch_dly <= fetch_go;   // RAM data valid next cycle
      if (fetch_go) begin
        fetch_pend <= 1'b0;
        addr       <= addr + 1'b1;   // Post-increment after fetch
      end
      if (acc_ctrl_wr) begin
        if (seq == seq_low) begin
          seq <= seq_high;
        end else begin
          seq  <= seq_low;   // Pair complete
          op   <= new_op;
          addr <= {bus_din[5:0], low_byte};
          if (new_op == op_reg_write) begin
            case (bus_din[3:0])
              4'd1:    disp_en  <= low_byte[6];
              4'd7:    backdrop <= low_byte[3:0];
              default: ;   // Other registers not kept
            endcase
          end
          if (new_op == op_vram_read) fetch_pend <= 1'b1;
        end
      end
      if (acc_data_wr) addr <= addr + 1'b1;
      if (acc_data_rd) fetch_pend <= 1'b1;   // Refill after the strobe ends
    end
  end

  // Low byte and read buffer
  always_ff @(posedge clk) begin
    if (acc_ctrl_wr && (seq == seq_low)) low_byte <= bus_din;
    if (fetch_dly)                       rd_buf   <= vram_rdata;
  end

  // --------------------
  // Memory port A
  assign vram_addr  = addr;
  assign vram_we    = acc_data_wr && (op == op_vram_write);
  assign vram_wdata = bus_din;
  assign cram_addr  = addr[4:0];
  assign cram_we    = acc_data_wr && (op == op_cram_write);
  assign cram_wdata = bus_din[5:0];   // 6-bit color

endmodule : vdp_cpu_port

`default_nettype wire

// ==== hdl/vdp_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module vdp_top #(
  parameter logic [7:0] ctrl_port = vdp_pkg::default_ctrl_port
) (
  input  logic       clk,
  input  logic       rst_L,
  // Z80 I/O bus
  input  logic       iorq_l,
  input  logic       rd_l,
  input  logic       wr_l,
  input  logic [7:0] bus_addr,
  input  logic [7:0] bus_din,
  output logic [7:0] bus_dout,
  output logic       bus_oe,
  // VGA
  output logic       vga_hs,
  output logic       vga_vs,
  output logic [3:0] vga_r,
  output logic [3:0] vga_g,
  output logic [3:0] vga_b
);

  import vdp_pkg::*;

  // CPU side of the memories
  vram_addr_t vram_a_addr;
  logic       vram_a_we;
  vram_byte_t vram_a_wdata, vram_a_rdata;
  cram_addr_t cram_a_addr;
  logic       cram_a_we;
  color_t     cram_a_wdata;

  // Display side
  vram_addr_t vram_b_addr;
  vram_byte_t vram_b_rdata;
  cram_addr_t cram_b_addr;
  color_t     cram_b_rdata;
  col_t       col;
  row_t       row;
  logic       h_sync, v_sync;
  logic       disp_en;
  logic [3:0] backdrop;

  // --------------------
  vdp_cpu_port #(.ctrl_port(ctrl_port)) cpu0 (
    .clk, .rst_L, .iorq_l, .rd_l, .wr_l, .bus_addr, .bus_din, .bus_dout, .bus_oe,
    .vram_addr(vram_a_addr), .vram_we(vram_a_we),
    .vram_wdata(vram_a_wdata), .vram_rdata(vram_a_rdata),
    .cram_addr(cram_a_addr), .cram_we(cram_a_we), .cram_wdata(cram_a_wdata),
    .disp_en, .backdrop
  );

  vdp_raster raster0 (
    .clk, .rst_L, .col, .row, .h_sync, .v_sync
  );

  vdp_pixel_pipe pipe0 (
    .clk, .rst_L, .col, .row, .h_sync, .v_sync, .disp_en, .backdrop,
    .vram_addr(vram_b_addr), .vram_rdata(vram_b_rdata),
    .cram_addr(cram_b_addr), .cram_rdata(cram_b_rdata),
    .vga_hs, .vga_vs, .vga_r, .vga_g, .vga_b
  );

  // --------------------
  // 16 KB VRAM
  vdp_dp_ram #(.word_t(vram_byte_t), .depth(16384)) vram0 (
    .clk,
    .a_addr(vram_a_addr), .a_we(vram_a_we), .a_wdata(vram_a_wdata),
    .a_rdata(vram_a_rdata),
    .b_addr(vram_b_addr), .b_rdata(vram_b_rdata)
  );

  // 32-entry palette
  vdp_dp_ram #(.word_t(color_t), .depth(32)) cram0 (
    .clk,
    .a_addr(cram_a_addr), .a_we(cram_a_we), .a_wdata(cram_a_wdata),
    .a_rdata(),   // No CPU readback of CRAM
    .b_addr(cram_b_addr), .b_rdata(cram_b_rdata)
  );

endmodule : vdp_top

`default_nettype wire

// ==== dv/vdp_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module vdp_tb;

  // --------------------
  // Display timing numbers
  localparam int line_cycles   = 800;
  localparam int frame_rows    = 525;
  localparam int frame_cycles  = line_cycles * frame_rows;
  localparam int vs_end_row    = 492;       // First row after the vsync pulse
  localparam int vs_low_cycles = 2 * line_cycles;
  localparam int hs_low_cycles = 96;

  logic       clk = 1'b0;
  logic       rst_L;
  logic       iorq_l, rd_l, wr_l;
  logic [7:0] bus_addr, bus_din, bus_dout;
  logic       bus_oe;
  logic       vga_hs, vga_vs;
  logic [3:0] vga_r, vga_g, vga_b;

  logic [7:0] kinds[$];             // Parsed stim records
  int         fa[$], fb[$], fc[$];
  int         px_row[$], px_col[$], px_rgb[$];  // Pending pixel checks
  int         cycles = 0;
  int         limit  = 0;

  vdp_top dut0 (
    .clk, .rst_L, .iorq_l, .rd_l, .wr_l, .bus_addr, .bus_din, .bus_dout, .bus_oe,
    .vga_hs, .vga_vs, .vga_r, .vga_g, .vga_b
  );

  always #50 clk = ~clk;   // 100 ns period

  task automatic abort_run();
    $display("=== FAIL ===");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic check_val(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Mismatch at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
      abort_run();
    end
  endtask

  // Hang guard, counts every clock
  always @(posedge clk) begin
    cycles++;
    if (cycles > limit) begin
      $display("Timeout after %0d cycles, stimulus did not complete", cycles);
      abort_run();
    end
  end

  // --------------------
  // One Z80 I/O access, 4-cycle strobe then idle
  task automatic bus_cycle(input bit is_rd, input logic [7:0] port, input logic [7:0] data);
    @(posedge clk);
    bus_addr <= port;
    bus_din  <= is_rd ? 8'h00 : data;
    iorq_l   <= 1'b0;
    rd_l     <= !is_rd;
    wr_l     <= is_rd;
    repeat (2) @(posedge clk);
    @(negedge clk);                   // Third strobe cycle
    if (is_rd) begin
      check_val("bus_oe", 1, bus_oe);
      check_val("bus_dout", data, bus_dout);
    end
    repeat (2) @(posedge clk);
    iorq_l <= 1'b1;
    rd_l   <= 1'b1;
    wr_l   <= 1'b1;
    repeat (2) @(posedge clk);
  endtask

  // Sync widths, then queued pixels in raster order
  task automatic scan_frame();
    int cyc;
    int hs_low;
    int vs_low;
    int target;
    @(negedge clk);
    while (vga_vs !== 1'b1) @(negedge clk);
    while (vga_vs !== 1'b0) @(negedge clk);
    vs_low = 0;
    while (vga_vs !== 1'b1) begin
      vs_low++;
      @(negedge clk);
    end
    check_val("vga_vs low cycles", vs_low_cycles, vs_low);
    cyc    = 0;                       // Output of row 492, col 0
    hs_low = 0;
    foreach (px_row[i]) begin
      target = ((px_row[i] - vs_end_row + frame_rows) % frame_rows) * line_cycles
               + px_col[i];
      if (target < cyc) begin
        $display("Pixel check at row %0d col %0d is out of raster order", px_row[i],
                 px_col[i]);
        abort_run();
      end
      while (cyc < target) begin
        if (cyc < line_cycles && vga_hs === 1'b0) hs_low++;
        @(negedge clk);
        cyc++;
      end
      check_val($sformatf("rgb(%0d,%0d)", px_row[i], px_col[i]), px_rgb[i],
                {vga_r, vga_g, vga_b});
    end
    check_val("vga_hs low cycles", hs_low_cycles, hs_low);
    px_row.delete();
    px_col.delete();
    px_rgb.delete();
  endtask

  // --------------------
  initial begin
    int         fd;
    int         n;
    int         a, b, c;
    int         batches;
    string      line;
    string      rest;
    logic [7:0] kind;
    rst_L    = 1'b0;
    iorq_l   = 1'b1;
    rd_l     = 1'b1;
    wr_l     = 1'b1;
    bus_addr = 8'h00;
    bus_din  = 8'h00;
    batches  = 0;

    fd = $fopen("dv/vdp_stim.txt", "r");
    if (fd == 0) begin
      $display("Cannot open stimulus file dv/vdp_stim.txt");
      abort_run();
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n == 0) break;              // Nothing left to read
      if (line.len() < 2) continue;
      kind = line.getc(0);
      if (kind == "#") continue;      // Comment line
      rest = line.substr(1, line.len() - 1);
      c    = 0;
      case (kind)
        "W", "R": n = $sscanf(rest, "%h %h", a, b);
        "P":      n = $sscanf(rest, "%d %d %h", a, b, c);
        default:  n = 0;
      endcase
      if ((kind == "P" && n != 3) || (kind != "P" && n != 2)) begin
        $display("Unreadable stimulus line: %s", line);
        abort_run();
      end
      if (kind == "P" && (kinds.size() == 0 || kinds[$] != "P")) batches++;
      kinds.push_back(kind);
      fa.push_back(a);
      fb.push_back(b);
      fc.push_back(c);
    end
    $fclose(fd);
    // Each pixel batch needs up to two frames
    limit = batches * 2 * frame_cycles + 10 * kinds.size() + 1000;

    repeat (3) @(posedge clk);
    rst_L <= 1'b1;
    @(negedge clk);
    check_val("bus_oe", 0, bus_oe);
    check_val("rgb after reset", 0, {vga_r, vga_g, vga_b});

    foreach (kinds[i]) begin
      case (kinds[i])
        "W": bus_cycle(1'b0, 8'(fa[i]), 8'(fb[i]));
        "R": bus_cycle(1'b1, 8'(fa[i]), 8'(fb[i]));
        default: begin
          px_row.push_back(fa[i]);
          px_col.push_back(fb[i]);
          px_rgb.push_back(fc[i]);
          if (i == kinds.size() - 1 || kinds[i + 1] != "P") scan_frame();
        end
      endcase
    end

    $display("=== PASS ===");
    $finish;
  end

endmodule : vdp_tb

`default_nettype wire

// ==== files.f ====
hdl/vdp_pkg.sv
hdl/vdp_dp_ram.sv
hdl/vdp_raster.sv
hdl/vdp_pixel_pipe.sv
hdl/vdp_cpu_port.sv
hdl/vdp_top.sv
dv/vdp_tb.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing -Wno-fatal
TOP      := vdp_tb
FILELIST := files.f
BUILD    := obj_dir
LOG      := sim.log
STIM     := dv/vdp_stim.txt

SRCS := $(shell cat $(FILELIST))
BIN  := $(BUILD)/V$(TOP)

.PHONY: all run check clean

all: check

# Rebuilt only when a source or the file list changes
$(BUILD)/V%: $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $* -f $(FILELIST) --Mdir $(BUILD)

run: $(BIN) $(STIM)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)

check: run
	@if grep -q "=== FAIL ===" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "=== PASS ===" $(LOG) || (echo "No pass line in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== dv/vdp_stim.txt ====
# W port byte | R port expected_byte | P row col expected_rgb
# Port and byte in hex, row and col in decimal, rgb as 3 hex digits r g b
W BF 40
W BF 81
W BF 03
W BF 87
W BF 01
W BF C0
W BE 03
W BE 0C
W BE 30
W BE 39
W BF 13
W BF C0
W BE 26
W BF 00
W BF 78
W BE 01
W BE 02
W BE 03
W BE 04
W BF 4A
W BF 78
W BE 12
W BF 00
W BF 38
R BE 01
R BE 02
R BE 03
R BE 04
P 10 10 A5A
P 50 70 F00
P 50 90 0F0
P 55 100 00F
P 60 120 5AF
P 85 230 0F0
P 100 700 000
P 300 600 A5A
W BF 00
W BF 81
P 50 70 000
P 300 600 000
